/* hdl/mdu_op_pkg.sv */
package mdu_op_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Unit operation codes
    ////////////////////////////////////////////////////////////////////////////

    localparam int MDUOP_SIZE = 3;

    localparam logic [MDUOP_SIZE-1:0] MDUOP_NOOP  = 3'd0;  // Nothing for the sequencer
    localparam logic [MDUOP_SIZE-1:0] MDUOP_MULT  = 3'd1;  // Signed product
    localparam logic [MDUOP_SIZE-1:0] MDUOP_MULTU = 3'd2;  // Unsigned product
    localparam logic [MDUOP_SIZE-1:0] MDUOP_DIV   = 3'd3;  // Signed quotient/remainder
    localparam logic [MDUOP_SIZE-1:0] MDUOP_DIVU  = 3'd4;  // Unsigned quotient/remainder

    ////////////////////////////////////////////////////////////////////////////
    // Arithmetic latency
    ////////////////////////////////////////////////////////////////////////////

    localparam int DELAY_SIZE = 4;

    // Cycles from the accepting edge to the result edge
    localparam logic [DELAY_SIZE-1:0] DELAY_MULT = 4'd5;
    localparam logic [DELAY_SIZE-1:0] DELAY_DIV  = 4'd10;

    ////////////////////////////////////////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////////////////////////////////////////

    localparam int DATA_W = 32;  // Operands, HI and LO

endpackage

/* hdl/mips_funct_pkg.sv */
package mips_funct_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // R-type funct field, SPECIAL opcode
    ////////////////////////////////////////////////////////////////////////////

    localparam int FUNCT_W = 6;

    // HI/LO moves
    localparam logic [FUNCT_W-1:0] FUNCT_MFHI  = 6'h10;
    localparam logic [FUNCT_W-1:0] FUNCT_MTHI  = 6'h11;
    localparam logic [FUNCT_W-1:0] FUNCT_MFLO  = 6'h12;
    localparam logic [FUNCT_W-1:0] FUNCT_MTLO  = 6'h13;

    // Multi-cycle arithmetic
    localparam logic [FUNCT_W-1:0] FUNCT_MULT  = 6'h18;
    localparam logic [FUNCT_W-1:0] FUNCT_MULTU = 6'h19;
    localparam logic [FUNCT_W-1:0] FUNCT_DIV   = 6'h1a;
    localparam logic [FUNCT_W-1:0] FUNCT_DIVU  = 6'h1b;

endpackage

/* hdl/mdu_decode.sv */
`timescale 1ns/1ns

module mdu_decode
    import mdu_op_pkg::*;
    import mips_funct_pkg::*;
(
    input  logic                  instr_valid,
    input  logic [FUNCT_W-1:0]    funct,
    input  logic [DATA_W-1:0]     hi,
    input  logic [DATA_W-1:0]     lo,
    input  logic                  busy,
    output logic [MDUOP_SIZE-1:0] operation,
    output logic                  mt_hi,
    output logic                  mt_lo,
    output logic [DATA_W-1:0]     rd_data,
    output logic                  stall
);

    logic mdu_instr;  // Any funct owned by this unit

    always_comb begin
        operation = MDUOP_NOOP;
        mt_hi     = 1'b0;
        mt_lo     = 1'b0;
        rd_data   = '0;
        mdu_instr = 1'b0;
        if (instr_valid) begin
            case (funct)
                FUNCT_MULT:  operation = MDUOP_MULT;
                FUNCT_MULTU: operation = MDUOP_MULTU;
                FUNCT_DIV:   operation = MDUOP_DIV;
                FUNCT_DIVU:  operation = MDUOP_DIVU;
                FUNCT_MTHI:  mt_hi     = 1'b1;
                FUNCT_MTLO:  mt_lo     = 1'b1;
                FUNCT_MFHI:  rd_data   = hi;
                FUNCT_MFLO:  rd_data   = lo;
                default:     ;
            endcase
            case (funct)
                FUNCT_MFHI, FUNCT_MTHI, FUNCT_MFLO, FUNCT_MTLO,
                FUNCT_MULT, FUNCT_MULTU, FUNCT_DIV, FUNCT_DIVU: mdu_instr = 1'b1;
                default: mdu_instr = 1'b0;
            endcase
        end
    end

    // Moves and reads must wait for an arithmetic result as well
    assign stall = mdu_instr && busy;

endmodule

/* hdl/mdu_core.sv */
`timescale 1ns/1ns

module mdu_core
    import mdu_op_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  hold,
    input  logic [MDUOP_SIZE-1:0] operation,
    input  logic                  mt_hi,
    input  logic                  mt_lo,
    input  logic [DATA_W-1:0]     rs_data,
    input  logic [DATA_W-1:0]     rt_data,
    output logic                  start,
    output logic                  busy,
    output logic                  move_we_hi,
    output logic                  move_we_lo,
    output logic [DATA_W-1:0]     move_data,
    output logic                  res_we,
    output logic [DATA_W-1:0]     res_hi,
    output logic [DATA_W-1:0]     res_lo
);

    logic [DELAY_SIZE-1:0] delay;
    logic [MDUOP_SIZE-1:0] operation_reg;
    logic [DATA_W-1:0]     operand1_reg;
    logic [DATA_W-1:0]     operand2_reg;
    logic                  ready;
    logic                  last_cycle;
    logic                  res_valid;

    assign ready      = !hold && delay == '0;
    assign start      = ready && operation != MDUOP_NOOP;
    assign busy       = delay != '0;
    assign last_cycle = delay == DELAY_SIZE'(1);

    ////////////////////////////////////////////////////////////////////////////
    // Sequencer
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            delay         <= '0;
            operation_reg <= MDUOP_NOOP;
        end else if (start) begin
            operation_reg <= operation;
            case (operation)
                MDUOP_MULT, MDUOP_MULTU: delay <= DELAY_MULT;
                MDUOP_DIV, MDUOP_DIVU:   delay <= DELAY_DIV;
                default:                 delay <= '0;  // Unknown code, stay idle
            endcase
        end else if (busy) begin
            delay <= delay - DELAY_SIZE'(1);
            if (last_cycle) begin
                operation_reg <= MDUOP_NOOP;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            operand1_reg <= rs_data;
            operand2_reg <= rt_data;
        end else if (last_cycle) begin
            operand1_reg <= '0;
            operand2_reg <= '0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Arithmetic
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        res_hi    = '0;
        res_lo    = '0;
        res_valid = 1'b0;
        case (operation_reg)
            MDUOP_MULT: begin
                {res_hi, res_lo} = $signed(operand1_reg) * $signed(operand2_reg);
                res_valid        = 1'b1;
            end
            MDUOP_MULTU: begin
                {res_hi, res_lo} = operand1_reg * operand2_reg;
                res_valid        = 1'b1;
            end
            MDUOP_DIV: begin
                if (operand2_reg != '0) begin
                    res_lo    = $signed(operand1_reg) / $signed(operand2_reg);
                    res_hi    = $signed(operand1_reg) % $signed(operand2_reg);
                    res_valid = 1'b1;
                end
            end
            MDUOP_DIVU: begin
                if (operand2_reg != '0) begin
                    res_lo    = operand1_reg / operand2_reg;
                    res_hi    = operand1_reg % operand2_reg;
                    res_valid = 1'b1;
                end
            end
            default: ;
        endcase
    end

    assign res_we = last_cycle && res_valid;  // Divide by zero writes nothing

    // Direct moves share the accept condition
    assign move_we_hi = ready && mt_hi;
    assign move_we_lo = ready && mt_lo;
    assign move_data  = rs_data;

endmodule

/* hdl/hilo_regs.sv */
`timescale 1ns/1ns

module hilo_regs (
    input  logic        clk,
    input  logic        reset,
    input  logic        move_we_hi,
    input  logic        move_we_lo,
    input  logic [31:0] move_data,
    input  logic        res_we,
    input  logic [31:0] res_hi,
    input  logic [31:0] res_lo,
    output logic [31:0] hi,
    output logic [31:0] lo
);

    logic [31:0] hi_reg;
    logic [31:0] lo_reg;

    always_ff @(posedge clk) begin
        if (reset) begin
            hi_reg <= '0;
            lo_reg <= '0;
        end else if (res_we) begin  // Arithmetic result, both halves
            hi_reg <= res_hi;
            lo_reg <= res_lo;
        end else if (move_we_hi) begin
            hi_reg <= move_data;
        end else if (move_we_lo) begin
            lo_reg <= move_data;
        end
    end

    assign hi = hi_reg;
    assign lo = lo_reg;

endmodule

/* hdl/mdu_top.sv */
`timescale 1ns/1ns

module mdu_top
    import mdu_op_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              instr_valid,
    input  logic [5:0]        funct,
    input  logic [DATA_W-1:0] rs_data,
    input  logic [DATA_W-1:0] rt_data,
    input  logic              hold,
    output logic [DATA_W-1:0] hi,
    output logic [DATA_W-1:0] lo,
    output logic [DATA_W-1:0] rd_data,
    output logic              busy,
    output logic              stall
);

    logic [MDUOP_SIZE-1:0] operation;
    logic                  mt_hi;
    logic                  mt_lo;
    logic                  move_we_hi;
    logic                  move_we_lo;
    logic [DATA_W-1:0]     move_data;
    logic                  res_we;
    logic [DATA_W-1:0]     res_hi;
    logic [DATA_W-1:0]     res_lo;

    mdu_decode u_decode (
        .instr_valid (instr_valid),
        .funct       (funct),
        .hi          (hi),
        .lo          (lo),
        .busy        (busy),
        .operation   (operation),
        .mt_hi       (mt_hi),
        .mt_lo       (mt_lo),
        .rd_data     (rd_data),
        .stall       (stall)
    );

    mdu_core u_core (
        .clk         (clk),
        .reset       (reset),
        .hold        (hold),
        .operation   (operation),
        .mt_hi       (mt_hi),
        .mt_lo       (mt_lo),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .start       (),  // Only needed inside the sequencer here
        .busy        (busy),
        .move_we_hi  (move_we_hi),
        .move_we_lo  (move_we_lo),
        .move_data   (move_data),
        .res_we      (res_we),
        .res_hi      (res_hi),
        .res_lo      (res_lo)
    );

    hilo_regs u_hilo (
        .clk         (clk),
        .reset       (reset),
        .move_we_hi  (move_we_hi),
        .move_we_lo  (move_we_lo),
        .move_data   (move_data),
        .res_we      (res_we),
        .res_hi      (res_hi),
        .res_lo      (res_lo),
        .hi          (hi),
        .lo          (lo)
    );

endmodule

/* sim/tb_mdu.sv */
`timescale 1ns/1ns

module tb_mdu
    import mdu_op_pkg::*;
    import mips_funct_pkg::*;
#(
    parameter int SEED = 11
);

    localparam int NUM_OPS     = 300;
    localparam int RESET_CYC   = 8;
    localparam int CYCLE_LIMIT = NUM_OPS * (int'(DELAY_DIV) + 4) + RESET_CYC;

    logic                clk;
    logic                reset;
    logic                instr_valid;
    logic [FUNCT_W-1:0]  funct;
    logic [DATA_W-1:0]   rs_data;
    logic [DATA_W-1:0]   rt_data;
    logic                hold;
    logic [DATA_W-1:0]   hi;
    logic [DATA_W-1:0]   lo;
    logic [DATA_W-1:0]   rd_data;
    logic                busy;
    logic                stall;

    int                  seed;
    int                  cycle_count;
    logic [DATA_W-1:0]   model_hi;
    logic [DATA_W-1:0]   model_lo;
    logic [64:0]         pending;        // {write, hi, lo} of the running operation
    int                  model_count;
    logic                exp_busy;
    logic                exp_stall;
    logic [DATA_W-1:0]   exp_rd;

    mdu_top UUT (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .funct       (funct),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .hold        (hold),
        .hi          (hi),
        .lo          (lo),
        .rd_data     (rd_data),
        .busy        (busy),
        .stall       (stall)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic stop_with_failure();
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
        stop_with_failure();
    endtask

    function automatic logic is_mdu_funct(input logic [FUNCT_W-1:0] f);
        return f inside {FUNCT_MFHI, FUNCT_MTHI, FUNCT_MFLO, FUNCT_MTLO,
                         FUNCT_MULT, FUNCT_MULTU, FUNCT_DIV, FUNCT_DIVU};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Reference arithmetic
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [64:0] expected_result(input logic [FUNCT_W-1:0] f,
                                                    input logic [31:0] a,
                                                    input logic [31:0] b);
        logic [63:0] res;
        logic [31:0] mag_a;
        logic [31:0] mag_b;
        logic [31:0] quo;
        logic [31:0] rem;
        logic        write;
        res   = 64'h0;
        write = 1'b1;
        case (f)
            FUNCT_MULT:  res = {{32{a[31]}}, a} * {{32{b[31]}}, b};
            FUNCT_MULTU: res = {32'h0, a} * {32'h0, b};
            FUNCT_DIV: begin
                if (b == 32'h0) begin
                    write = 1'b0;
                end else begin
                    mag_a = a[31] ? -a : a;
                    mag_b = b[31] ? -b : b;
                    quo   = mag_a / mag_b;
                    rem   = mag_a % mag_b;
                    if (a[31] != b[31]) quo = -quo;
                    if (a[31]) rem = -rem;  // Remainder follows the dividend
                    res = {rem, quo};
                end
            end
            FUNCT_DIVU: begin
                if (b == 32'h0) write = 1'b0;
                else res = {a % b, a / b};
            end
            default: write = 1'b0;
        endcase
        return {write, res};
    endfunction

    always @(posedge clk) begin
        if (reset) begin
            model_hi    <= '0;
            model_lo    <= '0;
            pending     <= '0;
            model_count <= 0;
        end else if (model_count != 0) begin
            model_count <= model_count - 1;
            if (model_count == 1 && pending[64]) begin
                model_hi <= pending[63:32];
                model_lo <= pending[31:0];
            end
        end else if (instr_valid && !hold) begin
            case (funct)
                FUNCT_MULT, FUNCT_MULTU: begin
                    pending     <= expected_result(funct, rs_data, rt_data);
                    model_count <= int'(DELAY_MULT);
                end
                FUNCT_DIV, FUNCT_DIVU: begin
                    pending     <= expected_result(funct, rs_data, rt_data);
                    model_count <= int'(DELAY_DIV);
                end
                FUNCT_MTHI: model_hi <= rs_data;
                FUNCT_MTLO: model_lo <= rs_data;
                default: ;
            endcase
        end
    end

    assign exp_busy  = model_count != 0;
    assign exp_stall = instr_valid && is_mdu_funct(funct) && exp_busy;
    assign exp_rd    = !instr_valid ? '0 :
                       funct == FUNCT_MFHI ? model_hi :
                       funct == FUNCT_MFLO ? model_lo : '0;

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    hilo_after_reset: assert property (@(posedge clk) reset |=> hi == '0 && lo == '0)
        else report_mismatch("{hi,lo}", {$sampled(hi), $sampled(lo)}, 64'h0);
    flags_after_reset: assert property (@(posedge clk) reset |=> !busy && !stall)
        else report_mismatch("{busy,stall}", {$sampled(busy), $sampled(stall)}, 64'h0);
    hi_follows_model: assert property (@(posedge clk) disable iff (reset) hi == model_hi)
        else report_mismatch("hi", $sampled(hi), $sampled(model_hi));
    lo_follows_model: assert property (@(posedge clk) disable iff (reset) lo == model_lo)
        else report_mismatch("lo", $sampled(lo), $sampled(model_lo));
    busy_follows_model: assert property (@(posedge clk) disable iff (reset) busy == exp_busy)
        else report_mismatch("busy", $sampled(busy), $sampled(exp_busy));
    stall_follows_model: assert property (@(posedge clk) disable iff (reset) stall == exp_stall)
        else report_mismatch("stall", $sampled(stall), $sampled(exp_stall));
    rd_data_follows_model: assert property (@(posedge clk) disable iff (reset) rd_data == exp_rd)
        else report_mismatch("rd_data", $sampled(rd_data), $sampled(exp_rd));

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            stop_with_failure();
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [FUNCT_W-1:0] pick_funct();
        logic [FUNCT_W-1:0] table_f [9];
        table_f = '{FUNCT_MFHI, FUNCT_MTHI, FUNCT_MFLO, FUNCT_MTLO, FUNCT_MULT,
                    FUNCT_MULTU, FUNCT_DIV, FUNCT_DIVU, 6'h20};  // Last is ADD
        return table_f[$unsigned($random(seed)) % 9];
    endfunction

    function automatic logic [31:0] pick_operand();
        logic [31:0] r;
        r = $random(seed);
        case ($unsigned($random(seed)) % 8)
            0:       return 32'h0;
            1:       return 32'hffff_ffff;
            2:       return 32'h8000_0000;
            3:       return {{24{r[31]}}, r[7:0]};  // Small divisors
            default: return r;
        endcase
    endfunction

    initial begin
        logic [FUNCT_W-1:0] f;
        logic [31:0]        a;
        logic [31:0]        b;
        logic               valid;
        logic               accepted;
        seed        = SEED;
        cycle_count = 0;
        reset       = 1'b1;
        instr_valid = 1'b1;  // MULT waiting through reset
        funct       = FUNCT_MULT;
        rs_data     = '0;
        rt_data     = '0;
        hold        = 1'b0;
        repeat (RESET_CYC) @(posedge clk);
        reset       <= 1'b0;
        instr_valid <= 1'b0;
        for (int n = 0; n < NUM_OPS; n++) begin
            f     = pick_funct();
            a     = pick_operand();
            b     = pick_operand();
            valid = ($random(seed) & 7) != 0;
            if (f == FUNCT_DIV && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
                b = 32'h1;  // Quotient overflow is unpredictable on MIPS
            end
            accepted = 1'b0;
            while (!accepted) begin
                @(posedge clk);
                instr_valid <= valid;
                funct       <= f;
                rs_data     <= a;
                rt_data     <= b;
                hold        <= ($random(seed) & 7) == 0;
                @(negedge clk);
                accepted = !stall && !hold;
            end
        end
        @(posedge clk);
        instr_valid <= 1'b0;
        hold        <= 1'b0;
        @(negedge clk);
        while (busy) @(negedge clk);
        @(posedge clk);  // Last result compared here
        @(negedge clk);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* list.f */
hdl/mdu_op_pkg.sv
hdl/mips_funct_pkg.sv
hdl/mdu_decode.sv
hdl/mdu_core.sv
hdl/hilo_regs.sv
hdl/mdu_top.sv
sim/tb_mdu.sv

/* Makefile */
# Verilator build and run for the multiply/divide unit

VERILATOR ?= verilator
TOP       ?= tb_mdu
SEED      ?= 11
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FILELIST  ?= list.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST RESULT: PASS" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
